//--- rtl/evu_params.svh
// event unit widths and register word offsets
`ifndef EVU_PARAMS_SVH
`define EVU_PARAMS_SVH

`define EVU_DATA_W     32
`define EVU_ADDR_W     6
`define EVU_NB_EVENTS  32
`define EVU_IRQ_ID_W   5
`define EVU_WORD_LSB   2

// word offsets inside the register space
`define EVU_REG_EVT_MASK              4'd0
`define EVU_REG_EVT_MASK_AND          4'd1
`define EVU_REG_EVT_MASK_OR           4'd2
`define EVU_REG_IRQ_MASK              4'd3
`define EVU_REG_IRQ_MASK_AND          4'd4
`define EVU_REG_IRQ_MASK_OR           4'd5
`define EVU_REG_CLOCK_STATUS          4'd6
`define EVU_REG_EVT_BUFFER            4'd7
`define EVU_REG_EVT_BUFFER_MASKED     4'd8
`define EVU_REG_EVT_BUFFER_IRQ_MASKED 4'd9
`define EVU_REG_BUFFER_CLEAR          4'd10
`define EVU_REG_EVT_WAIT              4'd14
`define EVU_REG_EVT_WAIT_CLEAR        4'd15

`endif

//--- rtl/evu_pkg.sv
// event unit shared types for register operations, state view and sleep control
`include "evu_params.svh"

package evu_pkg;

  // register word offsets, AND clears and OR sets the written bits
  typedef enum logic [`EVU_ADDR_W-`EVU_WORD_LSB-1:0] {
    EVT_MASK              = `EVU_REG_EVT_MASK,
    EVT_MASK_AND          = `EVU_REG_EVT_MASK_AND,
    EVT_MASK_OR           = `EVU_REG_EVT_MASK_OR,
    IRQ_MASK              = `EVU_REG_IRQ_MASK,
    IRQ_MASK_AND          = `EVU_REG_IRQ_MASK_AND,
    IRQ_MASK_OR           = `EVU_REG_IRQ_MASK_OR,
    CLOCK_STATUS          = `EVU_REG_CLOCK_STATUS,
    EVT_BUFFER            = `EVU_REG_EVT_BUFFER,
    EVT_BUFFER_MASKED     = `EVU_REG_EVT_BUFFER_MASKED,
    EVT_BUFFER_IRQ_MASKED = `EVU_REG_EVT_BUFFER_IRQ_MASKED,
    BUFFER_CLEAR          = `EVU_REG_BUFFER_CLEAR,
    EVT_WAIT              = `EVU_REG_EVT_WAIT,
    EVT_WAIT_CLEAR        = `EVU_REG_EVT_WAIT_CLEAR
  } evu_reg_e;

  typedef enum logic [1:0] {
    ACTIVE   = 2'd0,
    SLEEP    = 2'd1,
    IRQ_HOLD = 2'd2
  } evu_clk_state_e;

  typedef struct packed {
    logic                   valid;
    evu_reg_e               sel;
    logic [`EVU_DATA_W-1:0] data;
  } evu_wr_req_t;

  typedef struct packed {
    logic [`EVU_NB_EVENTS-1:0] evt_mask;
    logic [`EVU_NB_EVENTS-1:0] irq_mask;
    logic [`EVU_NB_EVENTS-1:0] buffer;
  } evu_reg_view_t;

  typedef struct packed {
    logic evt_pending;
    logic irq_pending;
  } evu_status_t;

  typedef struct packed {
    logic valid;
    logic clear;
  } evu_wait_req_t;

endpackage

//--- rtl/evu_axil_slave.sv
// event unit AXI4-Lite slave, turns bus accesses into register operations and read data
`timescale 1ns/1ps
`include "evu_params.svh"

module evu_axil_slave (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`EVU_ADDR_W-1:0]   awaddr_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [`EVU_DATA_W-1:0]   wdata_i,
  input  logic [`EVU_DATA_W/8-1:0] wstrb_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output logic                     bvalid_o,
  output logic [1:0]               bresp_o,
  input  logic                     bready_i,
  input  logic [`EVU_ADDR_W-1:0]   araddr_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output logic                     rvalid_o,
  output logic [`EVU_DATA_W-1:0]   rdata_o,
  output logic [1:0]               rresp_o,
  input  logic                     rready_i,
  output evu_pkg::evu_wr_req_t     wr_req_o,
  output evu_pkg::evu_wait_req_t   wait_req_o,
  input  logic                     wait_done_i,
  input  evu_pkg::evu_reg_view_t   view_i,
  input  logic                     clock_en_i
);
  import evu_pkg::*;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  evu_reg_e               wr_sel;
  evu_reg_e               rd_sel;
  logic                   wr_accept;
  logic                   rd_accept;
  logic                   rd_is_wait;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic                   wait_q;
  logic                   wait_clear_q;
  logic [`EVU_DATA_W-1:0] strb_mask;
  logic [`EVU_DATA_W-1:0] rd_data;
  logic [`EVU_DATA_W-1:0] wait_data;
  logic [`EVU_DATA_W-1:0] rdata_q;

  assign wr_sel = evu_reg_e'(awaddr_i[`EVU_ADDR_W-1:`EVU_WORD_LSB]);
  assign rd_sel = evu_reg_e'(araddr_i[`EVU_ADDR_W-1:`EVU_WORD_LSB]);

  // address and data are taken together, never while a response is pending
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = RESP_OKAY;

  // a read is outstanding while parked at the sleep controller or waiting for rready
  assign arready_o  = ~rvalid_q & ~wait_q;
  assign rd_accept  = arvalid_i & arready_o;
  assign rd_is_wait = (rd_sel == EVT_WAIT) || (rd_sel == EVT_WAIT_CLEAR);
  assign rvalid_o   = rvalid_q;
  assign rdata_o    = rdata_q;
  assign rresp_o    = RESP_OKAY;

  always_comb begin
    for (int i = 0; i < `EVU_DATA_W/8; i++) begin
      strb_mask[8*i +: 8] = {8{wstrb_i[i]}};
    end
  end

  // bytes without strobe keep the old mask value, and set/clear writes skip them
  always_comb begin
    wr_req_o.valid = wr_accept;
    wr_req_o.sel   = wr_sel;
    case (wr_sel)
      EVT_MASK: wr_req_o.data = (wdata_i & strb_mask) | (view_i.evt_mask & ~strb_mask);
      IRQ_MASK: wr_req_o.data = (wdata_i & strb_mask) | (view_i.irq_mask & ~strb_mask);
      default:  wr_req_o.data = wdata_i & strb_mask;
    endcase
  end

  // the wait request is seen in the acceptance cycle already
  assign wait_req_o.valid = wait_q | (rd_accept & rd_is_wait);
  assign wait_req_o.clear = wait_q ? wait_clear_q : (rd_sel == EVT_WAIT_CLEAR);

  assign wait_data = view_i.buffer & view_i.evt_mask;

  always_comb begin
    case (rd_sel)
      EVT_MASK:              rd_data = view_i.evt_mask;
      IRQ_MASK:              rd_data = view_i.irq_mask;
      CLOCK_STATUS:          rd_data = {{(`EVU_DATA_W-1){1'b0}}, clock_en_i};
      EVT_BUFFER:            rd_data = view_i.buffer;
      EVT_BUFFER_MASKED:     rd_data = view_i.buffer & view_i.evt_mask;
      EVT_BUFFER_IRQ_MASKED: rd_data = view_i.buffer & view_i.irq_mask;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
      wait_q       <= 1'b0;
      wait_clear_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end

      if (wait_done_i) begin
        wait_q <= 1'b0;
      end else if (rd_accept && rd_is_wait) begin
        wait_q       <= 1'b1;
        wait_clear_q <= (rd_sel == EVT_WAIT_CLEAR);
      end

      if ((rd_accept && !rd_is_wait) || wait_done_i) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // wait data is taken at wake-up, before the clear lands in the buffer
  always_ff @(posedge clk_i) begin
    if (wait_done_i) begin
      rdata_q <= wait_data;
    end else if (rd_accept && !rd_is_wait) begin
      rdata_q <= rd_data;
    end
  end

endmodule

//--- rtl/evu_event_regs.sv
// event unit register block, holds the masks and the event buffer
`timescale 1ns/1ps
`include "evu_params.svh"

module evu_event_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`EVU_NB_EVENTS-1:0] event_lines_i,
  input  evu_pkg::evu_wr_req_t      wr_req_i,
  input  logic                      buffer_clear_i,
  input  logic [`EVU_NB_EVENTS-1:0] ack_clear_i,
  output evu_pkg::evu_reg_view_t    view_o,
  output evu_pkg::evu_status_t      status_o
);
  import evu_pkg::*;

  logic [`EVU_NB_EVENTS-1:0] evt_mask_q;
  logic [`EVU_NB_EVENTS-1:0] evt_mask_d;
  logic [`EVU_NB_EVENTS-1:0] irq_mask_q;
  logic [`EVU_NB_EVENTS-1:0] irq_mask_d;
  logic [`EVU_NB_EVENTS-1:0] buffer_q;
  logic [`EVU_NB_EVENTS-1:0] buffer_d;
  logic [`EVU_NB_EVENTS-1:0] clear_bits;

  always_comb begin
    evt_mask_d = evt_mask_q;
    irq_mask_d = irq_mask_q;
    clear_bits = '0;

    if (wr_req_i.valid) begin
      case (wr_req_i.sel)
        EVT_MASK:     evt_mask_d = wr_req_i.data;
        EVT_MASK_AND: evt_mask_d = evt_mask_q & ~wr_req_i.data;
        EVT_MASK_OR:  evt_mask_d = evt_mask_q | wr_req_i.data;
        IRQ_MASK:     irq_mask_d = wr_req_i.data;
        IRQ_MASK_AND: irq_mask_d = irq_mask_q & ~wr_req_i.data;
        IRQ_MASK_OR:  irq_mask_d = irq_mask_q | wr_req_i.data;
        BUFFER_CLEAR: clear_bits = wr_req_i.data;
        default: ;
      endcase
    end

    // a wait-clear takes precedence over a software clear write
    if (buffer_clear_i) begin
      clear_bits = evt_mask_q;
    end

    // new pulses always survive, even on bits being cleared
    buffer_d = (buffer_q & ~clear_bits & ~ack_clear_i) | event_lines_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q <= '0;
      irq_mask_q <= '0;
      buffer_q   <= '0;
    end else begin
      evt_mask_q <= evt_mask_d;
      irq_mask_q <= irq_mask_d;
      buffer_q   <= buffer_d;
    end
  end

  assign view_o.evt_mask = evt_mask_q;
  assign view_o.irq_mask = irq_mask_q;
  assign view_o.buffer   = buffer_q;

  assign status_o.evt_pending = |(buffer_q & evt_mask_q);
  assign status_o.irq_pending = |(buffer_q & irq_mask_q);

endmodule

//--- rtl/evu_sleep_ctrl.sv
// event unit sleep controller, gates the core clock while a wait read is parked
`timescale 1ns/1ps

module evu_sleep_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  evu_pkg::evu_wait_req_t wait_req_i,
  input  evu_pkg::evu_status_t   status_i,
  input  logic                   core_busy_i,
  output logic                   wait_done_o,
  output logic                   buffer_clear_o,
  output logic                   core_clock_en_o
);
  import evu_pkg::*;

  evu_clk_state_e state_q;
  evu_clk_state_e state_d;

  always_comb begin
    state_d         = state_q;
    wait_done_o     = 1'b0;
    buffer_clear_o  = 1'b0;
    core_clock_en_o = 1'b1;

    case (state_q)
      ACTIVE: begin
        if (wait_req_i.valid) begin
          if (status_i.irq_pending) begin
            // let the core take its interrupt first
            state_d = IRQ_HOLD;
          end else if (status_i.evt_pending) begin
            wait_done_o    = 1'b1;
            buffer_clear_o = wait_req_i.clear;
          end else if (!core_busy_i) begin
            state_d = SLEEP;
          end
        end
      end

      SLEEP: begin
        core_clock_en_o = 1'b0;
        if (status_i.irq_pending) begin
          core_clock_en_o = 1'b1;
          state_d         = IRQ_HOLD;
        end else if (status_i.evt_pending) begin
          // clock comes back in the wake-up cycle
          core_clock_en_o = 1'b1;
          wait_done_o     = 1'b1;
          buffer_clear_o  = wait_req_i.clear;
          state_d         = ACTIVE;
        end
      end

      IRQ_HOLD: begin
        // the wait stays parked until the interrupt is acknowledged
        if (!status_i.irq_pending) begin
          if (status_i.evt_pending) begin
            wait_done_o    = 1'b1;
            buffer_clear_o = wait_req_i.clear;
            state_d        = ACTIVE;
          end else if (!core_busy_i) begin
            state_d = SLEEP;
          end
        end
      end

      default: begin
        state_d = ACTIVE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ACTIVE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- rtl/evu_irq_ctrl.sv
// event unit interrupt controller, picks the highest pending line and handles acknowledge
`timescale 1ns/1ps
`include "evu_params.svh"

module evu_irq_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  evu_pkg::evu_reg_view_t    view_i,
  input  logic                      core_irq_ack_i,
  input  logic [`EVU_IRQ_ID_W-1:0]  core_irq_ack_id_i,
  output logic                      core_irq_req_o,
  output logic [`EVU_IRQ_ID_W-1:0]  core_irq_id_o,
  output logic [`EVU_NB_EVENTS-1:0] ack_clear_o
);
  import evu_pkg::*;

  logic [`EVU_NB_EVENTS-1:0] irq_masked;
  logic                      irq_req_q;

  assign irq_masked = view_i.buffer & view_i.irq_mask;

  // higher line numbers win
  always_comb begin
    core_irq_id_o = '0;
    for (int i = 0; i < `EVU_NB_EVENTS; i++) begin
      if (irq_masked[i]) begin
        core_irq_id_o = i[`EVU_IRQ_ID_W-1:0];
      end
    end
  end

  always_comb begin
    ack_clear_o = '0;
    if (core_irq_ack_i) begin
      ack_clear_o[core_irq_ack_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_req_q <= 1'b0;
    end else begin
      irq_req_q <= |irq_masked;
    end
  end

  assign core_irq_req_o = irq_req_q;

endmodule

//--- rtl/evu_top.sv
// event unit top level, bus front end feeding the registers and both controllers
`timescale 1ns/1ps
`include "evu_params.svh"

module evu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`EVU_NB_EVENTS-1:0] event_lines_i,
  input  logic                      core_busy_i,
  input  logic                      core_irq_ack_i,
  input  logic [`EVU_IRQ_ID_W-1:0]  core_irq_ack_id_i,
  output logic                      core_irq_req_o,
  output logic [`EVU_IRQ_ID_W-1:0]  core_irq_id_o,
  output logic                      core_clock_en_o,
  input  logic [`EVU_ADDR_W-1:0]    awaddr_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [`EVU_DATA_W-1:0]    wdata_i,
  input  logic [`EVU_DATA_W/8-1:0]  wstrb_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  output logic                      bvalid_o,
  output logic [1:0]                bresp_o,
  input  logic                      bready_i,
  input  logic [`EVU_ADDR_W-1:0]    araddr_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  output logic                      rvalid_o,
  output logic [`EVU_DATA_W-1:0]    rdata_o,
  output logic [1:0]                rresp_o,
  input  logic                      rready_i
);
  import evu_pkg::*;

  evu_wr_req_t               wr_req;
  evu_wait_req_t             wait_req;
  evu_reg_view_t             view;
  evu_status_t               status;
  logic                      wait_done;
  logic                      buffer_clear;
  logic [`EVU_NB_EVENTS-1:0] ack_clear;

  evu_axil_slave evu_axil_slave_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bvalid_o    (bvalid_o),
    .bresp_o     (bresp_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rready_i    (rready_i),
    .wr_req_o    (wr_req),
    .wait_req_o  (wait_req),
    .wait_done_i (wait_done),
    .view_i      (view),
    .clock_en_i  (core_clock_en_o)
  );

  evu_event_regs evu_event_regs_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .event_lines_i  (event_lines_i),
    .wr_req_i       (wr_req),
    .buffer_clear_i (buffer_clear),
    .ack_clear_i    (ack_clear),
    .view_o         (view),
    .status_o       (status)
  );

  evu_sleep_ctrl evu_sleep_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wait_req_i      (wait_req),
    .status_i        (status),
    .core_busy_i     (core_busy_i),
    .wait_done_o     (wait_done),
    .buffer_clear_o  (buffer_clear),
    .core_clock_en_o (core_clock_en_o)
  );

  evu_irq_ctrl evu_irq_ctrl_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .view_i            (view),
    .core_irq_ack_i    (core_irq_ack_i),
    .core_irq_ack_id_i (core_irq_ack_id_i),
    .core_irq_req_o    (core_irq_req_o),
    .core_irq_id_o     (core_irq_id_o),
    .ack_clear_o       (ack_clear)
  );

endmodule

//--- test/tb_evu.sv
// event unit testbench with directed tests over the AXI4-Lite port and the core side signals
`timescale 1ns/1ps
`include "evu_params.svh"

module tb_evu;
  import evu_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;
  localparam int BUS_LIMIT       = 100;

  // AXI4-Lite OKAY response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                      clk;
  logic                      rst_n;
  logic [`EVU_NB_EVENTS-1:0] event_lines;
  logic                      core_busy;
  logic                      core_irq_ack;
  logic [`EVU_IRQ_ID_W-1:0]  core_irq_ack_id;
  logic                      core_irq_req;
  logic [`EVU_IRQ_ID_W-1:0]  core_irq_id;
  logic                      core_clock_en;
  logic [`EVU_ADDR_W-1:0]    awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [`EVU_DATA_W-1:0]    wdata;
  logic [`EVU_DATA_W/8-1:0]  wstrb;
  logic                      wvalid;
  logic                      wready;
  logic                      bvalid;
  logic [1:0]                bresp;
  logic                      bready;
  logic [`EVU_ADDR_W-1:0]    araddr;
  logic                      arvalid;
  logic                      arready;
  logic                      rvalid;
  logic [`EVU_DATA_W-1:0]    rdata;
  logic [1:0]                rresp;
  logic                      rready;

  integer seed;
  string  test_name;
  int     error_count;
  int     errors_at_start;
  int     tests_passed;
  int     tests_failed;
  logic   clk_watch;
  logic   clk_dropped;

  evu_top evu_top_inst (
    .clk_i (clk), .rst_ni (rst_n), .event_lines_i (event_lines), .core_busy_i (core_busy),
    .core_irq_ack_i (core_irq_ack), .core_irq_ack_id_i (core_irq_ack_id),
    .core_irq_req_o (core_irq_req), .core_irq_id_o (core_irq_id),
    .core_clock_en_o (core_clock_en),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bvalid_o (bvalid), .bresp_o (bresp), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rvalid_o (rvalid), .rdata_o (rdata), .rresp_o (rresp), .rready_i (rready)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // notes any cycle where the core clock was gated while watched
  always @(negedge clk) begin
    if (clk_watch && !core_clock_en) begin
      clk_dropped = 1'b1;
    end
  end

  function automatic logic [`EVU_ADDR_W-1:0] reg_addr(input evu_reg_e sel);
    return {sel, 2'b00};
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    error_count++;
  endtask

  task automatic check_data(input string what, input logic [`EVU_DATA_W-1:0] exp,
                            input logic [`EVU_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_irq_id(input string what, input logic [`EVU_IRQ_ID_W-1:0] exp,
                              input logic [`EVU_IRQ_ID_W-1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    int errs;
    errs = error_count - errors_at_start;
    if (errs == 0) begin
      $display("test %s passed", test_name);
      tests_passed++;
    end else begin
      $display("test %s failed with %0d errors", test_name, errs);
      tests_failed++;
    end
  endtask

  // ready is sampled at the falling edge and the transfer happens on the next rising edge
  task automatic write_issue(input evu_reg_e sel, input logic [`EVU_DATA_W-1:0] data);
    int   n;
    logic seen;
    n       = 0;
    seen    = 1'b0;
    awaddr  = reg_addr(sel);
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!seen && n < BUS_LIMIT) begin
      @(negedge clk);
      seen = awready & wready;
      @(posedge clk);
      #2;
      n++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!seen) begin
      report_error($sformatf("write to %s was never accepted", sel.name()));
    end
  endtask

  task automatic write_collect();
    int         n;
    logic       seen;
    logic [1:0] resp;
    n    = 0;
    seen = 1'b0;
    resp = '0;
    while (!seen && n < BUS_LIMIT) begin
      @(negedge clk);
      seen = bvalid;
      resp = bresp;
      @(posedge clk);
      #2;
      n++;
    end
    if (!seen) begin
      report_error("no write response arrived");
    end else begin
      check_resp("write response", RESP_OKAY, resp);
    end
  endtask

  task automatic read_issue(input evu_reg_e sel);
    int   n;
    logic seen;
    n       = 0;
    seen    = 1'b0;
    araddr  = reg_addr(sel);
    arvalid = 1'b1;
    while (!seen && n < BUS_LIMIT) begin
      @(negedge clk);
      seen = arready;
      @(posedge clk);
      #2;
      n++;
    end
    arvalid = 1'b0;
    if (!seen) begin
      report_error($sformatf("read of %s was never accepted", sel.name()));
    end
  endtask

  task automatic read_collect(output logic [`EVU_DATA_W-1:0] data);
    int         n;
    logic       seen;
    logic [1:0] resp;
    n    = 0;
    seen = 1'b0;
    data = '0;
    resp = '0;
    while (!seen && n < BUS_LIMIT) begin
      @(negedge clk);
      seen = rvalid;
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #2;
      n++;
    end
    if (!seen) begin
      report_error("no read response arrived");
    end else begin
      check_resp("read response", RESP_OKAY, resp);
    end
  endtask

  task automatic axi_write(input evu_reg_e sel, input logic [`EVU_DATA_W-1:0] data);
    write_issue(sel, data);
    write_collect();
  endtask

  task automatic axi_read(input evu_reg_e sel, output logic [`EVU_DATA_W-1:0] data);
    read_issue(sel);
    read_collect(data);
  endtask

  task automatic pulse_events(input logic [`EVU_NB_EVENTS-1:0] pattern);
    event_lines = pattern;
    @(posedge clk);
    #2;
    event_lines = '0;
  endtask

  task automatic ack_irq(input logic [`EVU_IRQ_ID_W-1:0] id);
    core_irq_ack    = 1'b1;
    core_irq_ack_id = id;
    @(posedge clk);
    #2;
    core_irq_ack = 1'b0;
  endtask

  // checks a plain, a clear and a set write against a running model
  task automatic exercise_mask(input evu_reg_e plain, input evu_reg_e and_r,
                               input evu_reg_e or_r);
    logic [`EVU_DATA_W-1:0] model;
    logic [`EVU_DATA_W-1:0] val;
    logic [`EVU_DATA_W-1:0] rd;
    val   = $random(seed);
    model = val;
    axi_write(plain, val);
    axi_read(plain, rd);
    check_data($sformatf("%s plain write", plain.name()), model, rd);
    val   = $random(seed);
    model = model & ~val;
    axi_write(and_r, val);
    axi_read(plain, rd);
    check_data($sformatf("%s clear write", and_r.name()), model, rd);
    val   = $random(seed);
    model = model | val;
    axi_write(or_r, val);
    axi_read(plain, rd);
    check_data($sformatf("%s set write", or_r.name()), model, rd);
  endtask

  task automatic test_mask_regs();
    start_test("mask_regs");
    exercise_mask(EVT_MASK, EVT_MASK_AND, EVT_MASK_OR);
    exercise_mask(IRQ_MASK, IRQ_MASK_AND, IRQ_MASK_OR);
    finish_test();
  endtask

  task automatic test_buffer_clear();
    logic [`EVU_DATA_W-1:0] evt_m;
    logic [`EVU_DATA_W-1:0] irq_m;
    logic [`EVU_DATA_W-1:0] pattern;
    logic [`EVU_DATA_W-1:0] clr;
    logic [`EVU_DATA_W-1:0] rd;
    evt_m   = $random(seed);
    irq_m   = $random(seed);
    pattern = $random(seed);
    clr     = $random(seed);
    start_test("buffer_clear");
    axi_write(BUFFER_CLEAR, '1);
    axi_write(EVT_MASK, evt_m);
    axi_write(IRQ_MASK, irq_m);
    pulse_events(pattern);
    axi_read(EVT_BUFFER, rd);
    check_data("buffer", pattern, rd);
    axi_read(EVT_BUFFER_MASKED, rd);
    check_data("event masked buffer", pattern & evt_m, rd);
    axi_read(EVT_BUFFER_IRQ_MASKED, rd);
    check_data("irq masked buffer", pattern & irq_m, rd);
    axi_write(BUFFER_CLEAR, clr);
    axi_read(EVT_BUFFER, rd);
    check_data("buffer after clear", pattern & ~clr, rd);
    axi_write(BUFFER_CLEAR, '1);
    axi_write(IRQ_MASK, '0);
    finish_test();
  endtask

  task automatic test_interrupt();
    logic [`EVU_DATA_W-1:0] rd;
    start_test("interrupt");
    axi_write(BUFFER_CLEAR, '1);
    axi_write(IRQ_MASK, '1);
    pulse_events((32'h1 << 5) | (32'h1 << 20));
    check_bit("request before register stage", 1'b0, core_irq_req);
    check_irq_id("id with two lines", 5'd20, core_irq_id);
    @(posedge clk);
    #2;
    check_bit("request raised", 1'b1, core_irq_req);
    ack_irq(5'd20);
    check_irq_id("id after first ack", 5'd5, core_irq_id);
    check_bit("request after first ack", 1'b1, core_irq_req);
    ack_irq(5'd5);
    // the request register follows the cleared buffer one edge later
    @(posedge clk);
    #2;
    check_bit("request after second ack", 1'b0, core_irq_req);
    axi_read(EVT_BUFFER, rd);
    check_data("buffer after acks", '0, rd);
    axi_write(IRQ_MASK, '0);
    finish_test();
  endtask

  task automatic test_wait_pending();
    logic [`EVU_DATA_W-1:0] mask_val;
    logic [`EVU_DATA_W-1:0] pattern;
    logic [`EVU_DATA_W-1:0] rd;
    mask_val = 32'h0f0f_0f0f;
    pattern  = $random(seed) | 32'h1;
    start_test("wait_pending");
    axi_write(IRQ_MASK, '0);
    axi_write(BUFFER_CLEAR, '1);
    axi_write(EVT_MASK, mask_val);
    pulse_events(pattern);
    clk_dropped = 1'b0;
    clk_watch   = 1'b1;
    axi_read(EVT_WAIT, rd);
    check_data("wait data", pattern & mask_val, rd);
    axi_read(EVT_BUFFER, rd);
    check_data("buffer after wait", pattern, rd);
    axi_read(EVT_WAIT_CLEAR, rd);
    check_data("wait clear data", pattern & mask_val, rd);
    axi_read(EVT_BUFFER, rd);
    check_data("buffer after wait clear", pattern & ~mask_val, rd);
    clk_watch = 1'b0;
    check_bit("clock gated during wait", 1'b0, clk_dropped);
    axi_write(BUFFER_CLEAR, '1);
    finish_test();
  endtask

  task automatic test_sleep_wake();
    logic [`EVU_DATA_W-1:0] line_bit;
    logic [`EVU_DATA_W-1:0] rd;
    logic                   early;
    line_bit = 32'h1 << 9;
    early    = 1'b0;
    start_test("sleep_wake");
    axi_write(IRQ_MASK, '0);
    axi_write(BUFFER_CLEAR, '1);
    axi_write(EVT_MASK, line_bit);
    core_busy = 1'b0;
    read_issue(EVT_WAIT);
    repeat (8) begin
      @(negedge clk);
      early = early | rvalid;
    end
    check_bit("read answered while asleep", 1'b0, early);
    check_bit("clock enable asleep", 1'b0, core_clock_en);
    @(posedge clk);
    #2;
    pulse_events(line_bit);
    check_bit("clock enable at wake-up", 1'b1, core_clock_en);
    read_collect(rd);
    check_data("wake-up data", line_bit, rd);
    axi_read(CLOCK_STATUS, rd);
    check_data("clock status", 32'h1, rd);
    axi_write(BUFFER_CLEAR, '1);
    finish_test();
  endtask

  task automatic test_back_pressure();
    logic [`EVU_DATA_W-1:0] mask_val;
    logic [`EVU_DATA_W-1:0] irq_val;
    logic [`EVU_DATA_W-1:0] or_val;
    logic [`EVU_DATA_W-1:0] rd;
    mask_val = $random(seed);
    irq_val  = $random(seed);
    or_val   = $random(seed);
    start_test("back_pressure");
    axi_write(EVT_MASK, mask_val);
    rready = 1'b0;
    bready = 1'b0;
    write_issue(IRQ_MASK, irq_val);
    read_issue(EVT_MASK);
    // a second write and read wait behind the held responses
    awaddr  = reg_addr(EVT_MASK_OR);
    wdata   = or_val;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    araddr  = reg_addr(IRQ_MASK);
    arvalid = 1'b1;
    repeat (6) begin
      @(negedge clk);
      check_bit("bvalid held", 1'b1, bvalid);
      check_bit("rvalid held", 1'b1, rvalid);
      check_data("rdata held", mask_val, rdata);
      check_bit("awready while response held", 1'b0, awready);
      check_bit("arready while response held", 1'b0, arready);
      @(posedge clk);
      #2;
    end
    rready = 1'b1;
    bready = 1'b1;
    fork
      begin
        write_issue(EVT_MASK_OR, or_val);
        write_collect();
      end
      begin
        read_issue(IRQ_MASK);
        read_collect(rd);
      end
    join
    check_data("irq mask from held write", irq_val, rd);
    axi_read(EVT_MASK, rd);
    check_data("event mask after queued write", mask_val | or_val, rd);
    axi_write(IRQ_MASK, '0);
    finish_test();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed            = 81241;
    error_count     = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    test_name       = "reset";
    clk_watch       = 1'b0;
    clk_dropped     = 1'b0;
    clk             = 1'b0;
    rst_n           = 1'b0;
    event_lines     = '0;
    core_busy       = 1'b0;
    core_irq_ack    = 1'b0;
    core_irq_ack_id = '0;
    awaddr          = '0;
    awvalid         = 1'b0;
    wdata           = '0;
    wstrb           = '0;
    wvalid          = 1'b0;
    bready          = 1'b1;
    araddr          = '0;
    arvalid         = 1'b0;
    rready          = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_bit("clock enable after reset", 1'b1, core_clock_en);
    test_mask_regs();
    test_buffer_clear();
    test_interrupt();
    test_wait_pending();
    test_sleep_wake();
    test_back_pressure();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+rtl
rtl/evu_pkg.sv
rtl/evu_axil_slave.sv
rtl/evu_event_regs.sv
rtl/evu_sleep_ctrl.sv
rtl/evu_irq_ctrl.sv
rtl/evu_top.sv
test/tb_evu.sv

//--- run.sh
#!/bin/sh
# compile the event unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f build.f --top-module tb_evu -o tb_evu_sim > build.log 2>&1 \
  || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/tb_evu_sim > sim.log 2>&1
cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
